// File: Makefile
# Verilator build and run of the NEO-PVC testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f neoPvc.f --top-module neoPvcTb -Mdir obj_dir
	./obj_dir/VneoPvcTb | tee sim.log
	@grep -q "all tests passed" sim.log || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir sim.log

// File: neoPvc.f
+incdir+verilog
verilog/pvcPkg.sv
verilog/pvcWriteIf.sv
verilog/pvcDecode.sv
verilog/pvcPaletteRegs.sv
verilog/pvcBankRegs.sv
verilog/pvcWorkRam.sv
verilog/pvcReadMux.sv
verilog/neoPvc.sv
tests/neoPvcTb.sv

// File: tests/neoPvcTb.sv
// NEO-PVC testbench driving CPU port writes and reads against a reference model
`default_nettype none

module neoPvcTb;
	import pvcPkg::*;

	logic CLK_48M = 1'b0;
	logic nRESET;
	logic enable;
	logic nPortOeL;
	logic nPortOeU;
	logic nPortWeL;
	logic nPortWeU;
	cpuAddr_t cpuAddr;
	cpuData_t dataIn;
	cpuData_t romData;
	cpuData_t dataOut;
	logic dataOeL;
	logic dataOeU;
	romAddr_t romAddr;
	logic ramReady;

	integer seed = 32'hae6a6381;
	int errorCount = 0;
	int checkCount = 0;

	// Reference state of the chip
	cpuData_t refRam [4096];
	logic [4:0] refRed;
	logic [4:0] refGreen;
	logic [4:0] refBlue;
	logic refShade;
	cpuData_t refPack;
	romAddr_t refBank;

	// Comparisons waiting for the comparing process
	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];

	always #5 CLK_48M = ~CLK_48M;

	neoPvc neoPvc_i (
		.CLK_48M  (CLK_48M),
		.nRESET   (nRESET),
		.enable   (enable),
		.nPortOeL (nPortOeL),
		.nPortOeU (nPortOeU),
		.nPortWeL (nPortWeL),
		.nPortWeU (nPortWeU),
		.cpuAddr  (cpuAddr),
		.dataIn   (dataIn),
		.romData  (romData),
		.dataOut  (dataOut),
		.dataOeL  (dataOeL),
		.dataOeU  (dataOeU),
		.romAddr  (romAddr),
		.ramReady (ramReady)
	);

	// ========================================
	// Reference model
	// ========================================
	function automatic cpuData_t refRead(input cpuAddr_t addr, input cpuData_t rom);
		cpuData_t word;
		word = rom;
		if (addr[19:13] == 7'h7F)
			word = refRam[addr[12:1]];
		// Ports 1, 2, 6, 8 and 9 shadow the RAM word below them
		if (addr[19:5] == 15'h7FFF) begin
			case (addr[4:1])
				4'd1: word = {3'b000, refGreen, 3'b000, refBlue};
				4'd2: word = {7'b0000000, refShade, 3'b000, refRed};
				4'd6: word = refPack;
				4'd8: word = {refBank[7:0], 8'hA0};
				4'd9: word = refBank[23:8];
				default: ;
			endcase
		end
		return word;
	endfunction

	function automatic void refWrite(input cpuAddr_t addr, input cpuData_t data,
		input logic [1:0] lanes);
		ramAddr_t word;
		word = addr[12:1];
		if (addr[19:13] == 7'h7F) begin
			if (lanes[1])
				refRam[word][15:8] = data[15:8];
			if (lanes[0])
				refRam[word][7:0] = data[7:0];
		end
		if (addr[19:5] == 15'h7FFF && lanes[1]) begin
			case (addr[4:1])
				4'd0: begin
					refShade = data[15];
					refRed = {data[11:8], data[14]};
					refGreen[0] = data[13];
					refBlue[0] = data[12];
				end
				4'd4: begin
					refPack[13] = data[8];
					refPack[7:4] = data[12:9];
				end
				4'd5: refPack[15] = data[8];
				4'd8: refBank[7:1] = data[15:9];
				4'd9: refBank[22:16] = data[14:8];
				default: ;
			endcase
		end
		if (addr[19:5] == 15'h7FFF && lanes[0]) begin
			case (addr[4:1])
				4'd0: begin
					refGreen[4:1] = data[7:4];
					refBlue[4:1] = data[3:0];
				end
				4'd4: begin
					refPack[12] = data[0];
					refPack[3:0] = data[4:1];
				end
				4'd5: begin
					refPack[14] = data[0];
					refPack[11:8] = data[4:1];
				end
				4'd9: refBank[15:8] = data[7:0];
				default: ;
			endcase
		end
	endfunction

	// ========================================
	// Checking
	// ========================================
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic expectValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		nameQ.push_back(name);
		expQ.push_back(expected);
		actQ.push_back(actual);
	endtask

	always @(negedge CLK_48M) begin
		while (nameQ.size() > 0)
			check(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
	end

	// ========================================
	// Stimulus helpers
	// ========================================
	function automatic cpuAddr_t portAddr(input logic [3:0] port);
		return {15'h7FFF, port};
	endfunction

	function automatic cpuAddr_t ramWordAddr();
		return {7'h7F, 12'($random(seed))};
	endfunction

	function automatic cpuAddr_t outsideAddr();
		cpuAddr_t addr;
		addr = cpuAddr_t'($random(seed));
		if (&addr[19:13])
			addr[19] = 1'b0;
		return addr;
	endfunction

	// Upper lane in bit 1, lower lane in bit 0
	function automatic logic [1:0] pickLanes();
		case ($unsigned($random(seed)) % 3)
			0: return 2'b11;
			1: return 2'b10;
			default: return 2'b01;
		endcase
	endfunction

	// Strobe low for three cycles, then high long enough for the next falling edge
	task automatic driveWrite(input cpuAddr_t addr, input cpuData_t data,
		input logic [1:0] lanes);
		@(posedge CLK_48M);
		cpuAddr <= addr;
		dataIn <= data;
		nPortWeU <= !lanes[1];
		nPortWeL <= !lanes[0];
		repeat (3) @(posedge CLK_48M);
		nPortWeU <= 1'b1;
		nPortWeL <= 1'b1;
		repeat (3) @(posedge CLK_48M);
	endtask

	task automatic cpuWrite(input cpuAddr_t addr, input cpuData_t data, input logic [1:0] lanes);
		driveWrite(addr, data, lanes);
		refWrite(addr, data, lanes);
	endtask

	task automatic cpuRead(input string name, input cpuAddr_t addr);
		cpuData_t expected;
		@(posedge CLK_48M);
		cpuAddr <= addr;
		romData <= cpuData_t'($random(seed));
		nPortOeU <= 1'b0;
		nPortOeL <= 1'b0;
		repeat (2) @(posedge CLK_48M);
		@(negedge CLK_48M);
		expected = refRead(addr, romData);
		expectValue(name, 32'(expected), 32'(dataOut));
		expectValue({name, " lane enables"}, 32'h3, 32'({dataOeU, dataOeL}));
		@(posedge CLK_48M);
		nPortOeU <= 1'b1;
		nPortOeL <= 1'b1;
	endtask

	task automatic checkRomAddr(input string name);
		cpuAddr_t addr;
		romAddr_t expected;
		addr = cpuAddr_t'($random(seed));
		@(posedge CLK_48M);
		cpuAddr <= addr;
		@(negedge CLK_48M);
		expected = enable ? refBank + {4'b0000, addr, 1'b0} : '0;
		expectValue(name, 32'(expected), 32'(romAddr));
	endtask

	task automatic waitRamReady();
		int cycles;
		cycles = 0;
		while (!ramReady && cycles < 5000) begin
			@(negedge CLK_48M);
			cycles++;
		end
	endtask

	task automatic drainChecks();
		int cycles;
		cycles = 0;
		while (nameQ.size() > 0 && cycles < 20) begin
			@(negedge CLK_48M);
			cycles++;
		end
		if (nameQ.size() > 0) begin
			errorCount++;
			$display("Comparisons were still pending after 20 cycles");
		end
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic testAfterReset();
		@(negedge CLK_48M);
		expectValue("lane enables after reset", 32'h0, 32'({dataOeU, dataOeL}));
		expectValue("ramReady during fill", 32'h0, 32'(ramReady));
		checkRomAddr("romAddr with zero bank");
		checkRomAddr("romAddr with zero bank");
		// The fill has already passed word 0 so an accepted write would change it
		driveWrite({7'h7F, 12'h000}, cpuData_t'($random(seed)) | 16'h0101, 2'b11);
		waitRamReady();
		if (!ramReady) begin
			errorCount++;
			$display("ramReady did not rise within 5000 cycles");
		end else begin
			cpuRead("write during fill", {7'h7F, 12'h000});
			for (int i = 0; i < 8; i++)
				cpuRead("fill pattern", ramWordAddr());
		end
	endtask

	task automatic testRam();
		cpuAddr_t written [24];
		for (int i = 0; i < 24; i++) begin
			written[i] = ramWordAddr();
			cpuWrite(written[i], cpuData_t'($random(seed)), pickLanes());
		end
		for (int i = 0; i < 24; i++)
			cpuRead("ram readback", written[i]);
		for (int i = 0; i < 6; i++)
			cpuRead("rom passthrough", outsideAddr());
	endtask

	task automatic testUnpack();
		for (int i = 0; i < 10; i++) begin
			cpuWrite(portAddr(4'd0), cpuData_t'($random(seed)), pickLanes());
			cpuRead("unpack green blue", portAddr(4'd1));
			cpuRead("unpack shade red", portAddr(4'd2));
		end
	endtask

	task automatic testPack();
		logic [3:0] port;
		for (int i = 0; i < 12; i++) begin
			port = ($random(seed) & 1) ? 4'd5 : 4'd4;
			cpuWrite(portAddr(port), cpuData_t'($random(seed)), pickLanes());
			cpuRead("packed word", portAddr(4'd6));
		end
	endtask

	task automatic testBank();
		for (int i = 0; i < 8; i++) begin
			cpuWrite(portAddr(4'd8), cpuData_t'($random(seed)), 2'b11);
			cpuWrite(portAddr(4'd9), cpuData_t'($random(seed)), pickLanes());
			cpuRead("bank port 8", portAddr(4'd8));
			cpuRead("bank port 9", portAddr(4'd9));
			checkRomAddr("romAddr bank sum");
		end
		// With the chip deselected nothing reaches the bus
		@(posedge CLK_48M);
		enable <= 1'b0;
		nPortOeU <= 1'b0;
		nPortOeL <= 1'b0;
		@(negedge CLK_48M);
		expectValue("lane enables while disabled", 32'h0, 32'({dataOeU, dataOeL}));
		checkRomAddr("romAddr while disabled");
		@(posedge CLK_48M);
		enable <= 1'b1;
		nPortOeU <= 1'b1;
		nPortOeL <= 1'b1;
	endtask

	initial begin
		for (int i = 0; i < 4096; i++)
			refRam[i] = {i[7:0], i[7:0]};
		refRed = '0;
		refGreen = '0;
		refBlue = '0;
		refShade = 1'b0;
		refPack = '0;
		refBank = '0;
		nRESET <= 1'b0;
		enable <= 1'b1;
		nPortOeL <= 1'b1;
		nPortOeU <= 1'b1;
		nPortWeL <= 1'b1;
		nPortWeU <= 1'b1;
		cpuAddr <= '0;
		dataIn <= '0;
		romData <= '0;
		repeat (3) @(posedge CLK_48M);
		nRESET <= 1'b1;
		testAfterReset();
		if (ramReady) begin
			testRam();
			testUnpack();
			testPack();
			testBank();
		end
		drainChecks();
		$display("Checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/neoPvc.sv
// NEO-PVC protection and bank-switching chip for the 68000 cartridge port bus
`default_nettype none

module neoPvc (
	input  logic             CLK_48M,
	input  logic             nRESET,
	input  logic             enable,
	input  logic             nPortOeL,
	input  logic             nPortOeU,
	input  logic             nPortWeL,
	input  logic             nPortWeU,
	input  pvcPkg::cpuAddr_t cpuAddr,
	input  pvcPkg::cpuData_t dataIn,
	input  pvcPkg::cpuData_t romData,
	output pvcPkg::cpuData_t dataOut,
	output logic             dataOeL,
	output logic             dataOeU,
	output pvcPkg::romAddr_t romAddr,
	output logic             ramReady
);
	import pvcPkg::*;

	pvcWriteIf wrBus ();

	ramAddr_t readAddr;
	portNo_t readPortNo;
	logic readInPort;
	logic readInRam;
	cpuData_t paletteData;
	logic paletteHit;
	cpuData_t bankData;
	logic bankHit;
	cpuData_t ramData;

	pvcDecode decode_i (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.enable     (enable),
		.nPortWeL   (nPortWeL),
		.nPortWeU   (nPortWeU),
		.cpuAddr    (cpuAddr),
		.dataIn     (dataIn),
		.wr         (wrBus.source),
		.readAddr   (readAddr),
		.readPortNo (readPortNo),
		.readInPort (readInPort),
		.readInRam  (readInRam)
	);

	pvcPaletteRegs palette_i (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.wr         (wrBus.sink),
		.readInPort (readInPort),
		.readPortNo (readPortNo),
		.readData   (paletteData),
		.readHit    (paletteHit)
	);

	pvcBankRegs bank_i (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.enable     (enable),
		.wr         (wrBus.sink),
		.cpuAddr    (cpuAddr),
		.readInPort (readInPort),
		.readPortNo (readPortNo),
		.readData   (bankData),
		.readHit    (bankHit),
		.romAddr    (romAddr)
	);

	pvcWorkRam ram_i (
		.CLK_48M  (CLK_48M),
		.nRESET   (nRESET),
		.wr       (wrBus.sink),
		.readAddr (readAddr),
		.ramData  (ramData),
		.ramReady (ramReady)
	);

	pvcReadMux mux_i (
		.nPortOeL    (nPortOeL),
		.nPortOeU    (nPortOeU),
		.enable      (enable),
		.paletteData (paletteData),
		.paletteHit  (paletteHit),
		.bankData    (bankData),
		.bankHit     (bankHit),
		.ramData     (ramData),
		.readInRam   (readInRam),
		.romData     (romData),
		.dataOut     (dataOut),
		.dataOeL     (dataOeL),
		.dataOeU     (dataOeU)
	);

endmodule

`default_nettype wire

// File: verilog/pvcBankRegs.sv
// PVC program-ROM bank base registers and the outgoing ROM address adder
`default_nettype none
`include "pvc_cfg.svh"

module pvcBankRegs (
	input  logic             CLK_48M,
	input  logic             nRESET,
	input  logic             enable,
	pvcWriteIf.sink          wr,
	input  pvcPkg::cpuAddr_t cpuAddr,
	input  logic             readInPort,
	input  pvcPkg::portNo_t  readPortNo,
	output pvcPkg::cpuData_t readData,
	output logic             readHit,
	output pvcPkg::romAddr_t romAddr
);
	import pvcPkg::*;

	romAddr_t bank;

	// Bit 0 and bit 23 of the base are hardwired low by the write mapping
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			bank <= '0;
		end else begin
			if (wr.upperWrite && wr.inPort) begin
				if (wr.portNo == `PVC_PORT_BANK_LO)
					bank[7:0] <= {wr.data[15:9], 1'b0};
				if (wr.portNo == `PVC_PORT_BANK_HI)
					bank[23:16] <= {1'b0, wr.data[14:8]};
			end
			if (wr.lowerWrite && wr.inPort && wr.portNo == `PVC_PORT_BANK_HI)
				bank[15:8] <= wr.data[7:0];
		end
	end

	always_comb begin
		readData = '0;
		readHit  = 1'b0;
		if (readInPort) begin
			case (readPortNo)
				`PVC_PORT_BANK_LO: begin
					readHit  = 1'b1;
					readData = {bank[7:0], `PVC_BANK_FILLER};
				end
				`PVC_PORT_BANK_HI: begin
					readHit  = 1'b1;
					readData = bank[23:8];
				end
				default: ;
			endcase
		end
	end

	// Byte address is the word address shifted up by one
	assign romAddr = enable ? bank + {4'b0000, cpuAddr, 1'b0} : '0;

	assert property (@(posedge CLK_48M) disable iff (!nRESET) !bank[0] && !bank[23]);

endmodule

`default_nettype wire

// File: verilog/pvcDecode.sv
// PVC decode stage turning write strobe edges into write events and latching read addresses
`default_nettype none
`include "pvc_cfg.svh"

module pvcDecode (
	input  logic             CLK_48M,
	input  logic             nRESET,
	input  logic             enable,
	input  logic             nPortWeL,
	input  logic             nPortWeU,
	input  pvcPkg::cpuAddr_t cpuAddr,
	input  pvcPkg::cpuData_t dataIn,
	pvcWriteIf.source        wr,
	output pvcPkg::ramAddr_t readAddr,
	output pvcPkg::portNo_t  readPortNo,
	output logic             readInPort,
	output logic             readInRam
);
	import pvcPkg::*;

	// Highest word address bit that still lies inside the RAM
	localparam int RamTop = $clog2(`PVC_RAM_WORDS);

	logic weUSync;
	logic weLSync;
	logic weUPrev;
	logic weLPrev;
	logic fallU;
	logic fallL;
	logic ramHit;
	logic portHit;

	// The port region sits inside the RAM region
	assign ramHit  = &cpuAddr[19:RamTop + 1];
	assign portHit = &cpuAddr[19:5];

	// A strobe falls when the older sample is high and the newer one low
	assign fallU = weUPrev & ~weUSync;
	assign fallL = weLPrev & ~weLSync;

	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			weUSync       <= 1'b1;
			weLSync       <= 1'b1;
			weUPrev       <= 1'b1;
			weLPrev       <= 1'b1;
			wr.upperWrite <= 1'b0;
			wr.lowerWrite <= 1'b0;
			wr.inPort     <= 1'b0;
			wr.inRam      <= 1'b0;
			readInPort    <= 1'b0;
			readInRam     <= 1'b0;
		end else begin
			weUSync       <= nPortWeU;
			weLSync       <= nPortWeL;
			weUPrev       <= weUSync;
			weLPrev       <= weLSync;
			wr.upperWrite <= fallU & enable;
			wr.lowerWrite <= fallL & enable;
			if (fallU || fallL) begin
				wr.inPort <= portHit;
				wr.inRam  <= ramHit;
			end
			readInPort <= portHit;
			readInRam  <= ramHit;
		end
	end

	// Write payload and read address
	always_ff @(posedge CLK_48M) begin
		if (fallU || fallL) begin
			wr.portNo  <= cpuAddr[4:1];
			wr.ramAddr <= cpuAddr[RamTop:1];
			wr.data    <= dataIn;
		end
		readAddr   <= cpuAddr[RamTop:1];
		readPortNo <= cpuAddr[4:1];
	end

	// Every stage downstream relies on a port write also being a RAM write
	assert property (@(posedge CLK_48M) disable iff (!nRESET) wr.inPort |-> wr.inRam);

endmodule

`default_nettype wire

// File: verilog/pvcPaletteRegs.sv
// PVC palette registers that unpack a palette word into fields and pack fields into a word
`default_nettype none
`include "pvc_cfg.svh"

module pvcPaletteRegs (
	input  logic             CLK_48M,
	input  logic             nRESET,
	pvcWriteIf.sink          wr,
	input  logic             readInPort,
	input  pvcPkg::portNo_t  readPortNo,
	output pvcPkg::cpuData_t readData,
	output logic             readHit
);
	import pvcPkg::*;

	logic [4:0] red;
	logic [4:0] green;
	logic [4:0] blue;
	logic shade;
	cpuData_t packWord;

	// ========================================
	// Writes
	// ========================================
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			red      <= '0;
			green    <= '0;
			blue     <= '0;
			shade    <= 1'b0;
			packWord <= '0;
		end else begin
			if (wr.upperWrite && wr.inPort) begin
				case (wr.portNo)
					`PVC_PORT_UNPACK: begin
						// Low bits of red, green and blue live in the top nibble
						shade    <= wr.data[15];
						red      <= {wr.data[11:8], wr.data[14]};
						green[0] <= wr.data[13];
						blue[0]  <= wr.data[12];
					end
					`PVC_PORT_PACK_LO: begin
						packWord[13]  <= wr.data[8];
						packWord[7:4] <= wr.data[12:9];
					end
					`PVC_PORT_PACK_HI: packWord[15] <= wr.data[8];
					default: ;
				endcase
			end
			if (wr.lowerWrite && wr.inPort) begin
				case (wr.portNo)
					`PVC_PORT_UNPACK: begin
						green[4:1] <= wr.data[7:4];
						blue[4:1]  <= wr.data[3:0];
					end
					`PVC_PORT_PACK_LO: begin
						packWord[12]  <= wr.data[0];
						packWord[3:0] <= wr.data[4:1];
					end
					`PVC_PORT_PACK_HI: begin
						packWord[14]   <= wr.data[0];
						packWord[11:8] <= wr.data[4:1];
					end
					default: ;
				endcase
			end
		end
	end

	// ========================================
	// Readback
	// ========================================
	always_comb begin
		readData = '0;
		readHit  = 1'b0;
		if (readInPort) begin
			case (readPortNo)
				`PVC_PORT_READ_GB: begin
					readHit  = 1'b1;
					readData = {3'b000, green, 3'b000, blue};
				end
				`PVC_PORT_READ_RS: begin
					readHit  = 1'b1;
					readData = {7'b0000000, shade, 3'b000, red};
				end
				`PVC_PORT_READ_PACK: begin
					readHit  = 1'b1;
					readData = packWord;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/pvcPkg.sv
// PVC shared types for addresses, data words and the RAM fill state machine
`default_nettype none

package pvcPkg;

	// CPU word address as seen on the 68000 port bus, A0 is not present
	typedef logic [19:1] cpuAddr_t;

	// One 16-bit CPU data word
	typedef logic [15:0] cpuData_t;

	// Port number inside the 16-port region at the top of the window
	typedef logic [3:0] portNo_t;

	// Program-ROM byte address, also used for the bank base
	typedef logic [23:0] romAddr_t;

	// Work RAM word address
	typedef logic [11:0] ramAddr_t;

	// RAM fill machine
	// fillIdle is the state right after reset is released
	typedef enum logic [1:0] {
		fillIdle,
		fillRun,
		fillDone
	} fillState_t;

endpackage

`default_nettype wire

// File: verilog/pvcReadMux.sv
// PVC read mux choosing port registers, work RAM or program-ROM data for the CPU
`default_nettype none

module pvcReadMux (
	input  logic             nPortOeL,
	input  logic             nPortOeU,
	input  logic             enable,
	input  pvcPkg::cpuData_t paletteData,
	input  logic             paletteHit,
	input  pvcPkg::cpuData_t bankData,
	input  logic             bankHit,
	input  pvcPkg::cpuData_t ramData,
	input  logic             readInRam,
	input  pvcPkg::cpuData_t romData,
	output pvcPkg::cpuData_t dataOut,
	output logic             dataOeL,
	output logic             dataOeU
);
	import pvcPkg::*;

	// Port registers shadow the RAM words they overlap
	always_comb begin
		if (paletteHit)
			dataOut = paletteData;
		else if (bankHit)
			dataOut = bankData;
		else if (readInRam)
			dataOut = ramData;
		else
			dataOut = romData;
	end

	// Lane enables follow the CPU strobes directly
	assign dataOeL = !nPortOeL && enable;
	assign dataOeU = !nPortOeU && enable;

endmodule

`default_nettype wire

// File: verilog/pvcWorkRam.sv
// PVC 4K by 16 work RAM with byte lanes, a registered read and a pattern fill after reset
`default_nettype none
`include "pvc_cfg.svh"

module pvcWorkRam (
	input  logic             CLK_48M,
	input  logic             nRESET,
	pvcWriteIf.sink          wr,
	input  pvcPkg::ramAddr_t readAddr,
	output pvcPkg::cpuData_t ramData,
	output logic             ramReady
);
	import pvcPkg::*;

	logic [7:0] laneU [`PVC_RAM_WORDS];
	logic [7:0] laneL [`PVC_RAM_WORDS];
	fillState_t fillState;
	ramAddr_t fillAddr;
	logic filling;
	logic cpuWeU;
	logic cpuWeL;

	assign filling  = (fillState == fillRun);
	assign ramReady = (fillState == fillDone);

	// CPU writes are dropped until the fill has finished
	assign cpuWeU = wr.upperWrite && wr.inRam && ramReady;
	assign cpuWeL = wr.lowerWrite && wr.inRam && ramReady;

	// ========================================
	// Fill machine
	// ========================================
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			fillState <= fillIdle;
			fillAddr  <= '0;
		end else begin
			case (fillState)
				fillIdle: fillState <= fillRun;
				fillRun: begin
					fillAddr <= fillAddr + 1'b1;
					if (&fillAddr)
						fillState <= fillDone;
				end
				fillDone: ;
				default: fillState <= fillIdle;
			endcase
		end
	end

	// ========================================
	// Storage
	// ========================================
	always_ff @(posedge CLK_48M) begin
		if (filling) begin
			laneU[fillAddr] <= fillAddr[7:0];
			laneL[fillAddr] <= fillAddr[7:0];
		end else begin
			if (cpuWeU)
				laneU[wr.ramAddr] <= wr.data[15:8];
			if (cpuWeL)
				laneL[wr.ramAddr] <= wr.data[7:0];
		end
		ramData <= {laneU[readAddr], laneL[readAddr]};
	end

	// A CPU write during the fill leaves the addressed word as it was
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		filling && wr.upperWrite && wr.inRam && wr.ramAddr != fillAddr
			|=> laneU[$past(wr.ramAddr)] == $past(laneU[wr.ramAddr]));
	assert property (@(posedge CLK_48M) disable iff (!nRESET)
		filling && wr.lowerWrite && wr.inRam && wr.ramAddr != fillAddr
			|=> laneL[$past(wr.ramAddr)] == $past(laneL[wr.ramAddr]));

endmodule

`default_nettype wire

// File: verilog/pvcWriteIf.sv
// PVC write event bus from the decode stage to the register and RAM stages
`default_nettype none

interface pvcWriteIf;
	import pvcPkg::*;

	// One-cycle pulses, one per byte lane
	logic upperWrite;
	logic lowerWrite;

	// Region flags captured with the pulse
	logic inPort;
	logic inRam;

	// Target and payload, valid only while a pulse is high
	portNo_t portNo;
	ramAddr_t ramAddr;
	cpuData_t data;

	modport source (
		output upperWrite,
		output lowerWrite,
		output inPort,
		output inRam,
		output portNo,
		output ramAddr,
		output data
	);

	modport sink (
		input upperWrite,
		input lowerWrite,
		input inPort,
		input inRam,
		input portNo,
		input ramAddr,
		input data
	);

endinterface

`default_nettype wire

// File: verilog/pvc_cfg.svh
// PVC configuration constants for the work RAM, the port map and the read filler
`ifndef PVC_CFG_SVH
`define PVC_CFG_SVH

// Work RAM depth in 16-bit words, the top 8 KB of the window
`define PVC_RAM_WORDS 4096

// Palette unpack and pack ports
`define PVC_PORT_UNPACK    4'd0
`define PVC_PORT_READ_GB   4'd1
`define PVC_PORT_READ_RS   4'd2
`define PVC_PORT_PACK_LO   4'd4
`define PVC_PORT_PACK_HI   4'd5
`define PVC_PORT_READ_PACK 4'd6

// Program-ROM bank base ports
`define PVC_BANK_FILLER    8'hA0
`define PVC_PORT_BANK_LO   4'd8
`define PVC_PORT_BANK_HI   4'd9

`endif
